// ==== hw/fmd_macros.svh ====
`ifndef FMD_MACROS_SVH
`define FMD_MACROS_SVH

// significand width, hidden bit included.
`define MD_SIG_W 53

// result width, 56 result bits and a sticky bit.
`define MD_FQ_W 57

// number of lanes, 2 to 8.
`define MD_LANES 4

`define MD_TAG_W 4

// newton-raphson rounds for single and double precision.
`define MD_NR_SP 2
`define MD_NR_DP 3

`endif

// ==== hw/fmd_pkg.sv ====
`default_nettype none
`include "fmd_macros.svh"

package fmd_pkg;

    typedef enum logic [0:0] {
        OP_MUL = 1'b0,
        OP_DIV = 1'b1
    } md_op_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_MUL,
        S_SEED,
        S_NR_A,  // t = b*x.
        S_NR_B,  // x = x*(2 - t).
        S_QUOT,
        S_CORR,
        S_DONE
    } lane_state_e;

    typedef struct packed {
        md_op_e                op;
        logic                  db;   // double precision.
        logic [`MD_SIG_W-1:0]  fa;
        logic [`MD_SIG_W-1:0]  fb;
        logic [`MD_TAG_W-1:0]  tag;
    } md_req_t;

    typedef struct packed {
        logic [`MD_FQ_W-1:0]   fq;
        logic [`MD_TAG_W-1:0]  tag;
    } md_rsp_t;

endpackage

`default_nettype wire

// ==== hw/md_collect.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fmd_macros.svh"

module md_collect import fmd_pkg::*; (
    input  wire logic [`MD_LANES-1:0] lane_done,
    input  wire md_rsp_t              lane_rsp [`MD_LANES],
    output logic      [`MD_LANES-1:0] lane_ack,
    output logic                      rsp_valid,
    output md_rsp_t                   rsp
);

    localparam int N = `MD_LANES;

    // fixed priority, lane 0 first.
    assign lane_ack  = lane_done & (~lane_done + N'(1));
    assign rsp_valid = |lane_done;

    always_comb begin
        rsp = '0;
        for (int i = 0; i < N; i++) begin
            if (lane_ack[i]) begin
                rsp = lane_rsp[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/md_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fmd_macros.svh"

module md_dispatch import fmd_pkg::*; (
    input  wire logic                 req_valid,
    input  wire md_req_t              req,
    input  wire logic [`MD_LANES-1:0] lane_idle,
    output logic      [`MD_LANES-1:0] lane_start,
    output md_req_t                   lane_req,
    output logic                      busy
);

    localparam int N = `MD_LANES;

    logic [N-1:0] lowest;

    // lowest set bit of the idle vector.
    assign lowest = lane_idle & (~lane_idle + N'(1));

    assign lane_start = req_valid ? lowest : '0;

    // every lane gets the request, only the started one keeps it.
    assign lane_req = req;

    // a lane being started this cycle no longer counts as idle.
    assign busy = ~|(lane_idle & ~lane_start);

endmodule

`default_nettype wire

// ==== hw/recip_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

// entry i holds the bits below the leading one of 1/m,
// m = 1.i plus half a step, so 1/m = 0.1dddddddd.
module recip_rom (
    input  wire logic [7:0] addr,
    output logic      [7:0] data
);

    function automatic logic [7:0] seed_of(input int idx);
        int q;
        // 2/m scaled by 256, m in 1/512 units is 513 + 2*idx.
        q = 262144 / (513 + 2 * idx);
        return 8'(q - 256);
    endfunction

    logic [7:0] seed_tbl [256];

    for (genvar i = 0; i < 256; i++) begin : g_tbl
        assign seed_tbl[i] = seed_of(i);
    end

    assign data = seed_tbl[addr];

endmodule

`default_nettype wire

// ==== hw/sig_md_cluster.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fmd_macros.svh"

module sig_md_cluster import fmd_pkg::*; (
    input  wire logic    clk,
    input  wire logic    arst_n,
    input  wire logic    req_valid,
    input  wire md_req_t req,
    output logic         busy,
    output logic         rsp_valid,
    output md_rsp_t      rsp
);

    logic [`MD_LANES-1:0] lane_start;
    logic [`MD_LANES-1:0] lane_idle;
    logic [`MD_LANES-1:0] lane_done;
    logic [`MD_LANES-1:0] lane_ack;
    md_req_t              lane_req;
    md_rsp_t              lane_rsp [`MD_LANES];

    md_dispatch u_dispatch (
        .req_valid  (req_valid),
        .req        (req),
        .lane_idle  (lane_idle),
        .lane_start (lane_start),
        .lane_req   (lane_req),
        .busy       (busy)
    );

    for (genvar i = 0; i < `MD_LANES; i++) begin : g_lane
        sig_md_lane u_lane (
            .clk    (clk),
            .arst_n (arst_n),
            .start  (lane_start[i]),
            .req    (lane_req),
            .idle   (lane_idle[i]),
            .done   (lane_done[i]),
            .rsp    (lane_rsp[i]),
            .ack    (lane_ack[i])
        );
    end

    md_collect u_collect (
        .lane_done (lane_done),
        .lane_rsp  (lane_rsp),
        .lane_ack  (lane_ack),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

`default_nettype wire

// ==== hw/sig_md_lane.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fmd_macros.svh"

module sig_md_lane import fmd_pkg::*; (
    input  wire logic    clk,
    input  wire logic    arst_n,
    input  wire logic    start,
    input  wire md_req_t req,
    output logic         idle,
    output logic         done,
    output md_rsp_t      rsp,
    input  wire logic    ack
);

    localparam int MW = `MD_SIG_W + 5;  // multiplier operand width.
    localparam int RW = 84;             // signed remainder width.

    lane_state_e     state;
    md_req_t         req_q;
    logic [2:0]      iter;
    logic [1:0]      ph;     // corr phase: rem, refine, rem, adjust.
    logic [7:0]      seed;
    logic [MW-1:0]   x;      // reciprocal, 57 fraction bits.
    logic [MW-1:0]   e;
    logic [MW-2:0]   q;
    logic [RW-1:0]   r;
    logic [MW-1:0]   r_hi;
    logic [RW-1:0]   fb_ext;
    logic [MW-1:0]   mul_a;
    logic [MW-1:0]   mul_b;
    logic [2*MW-1:0] prod;
    logic [2*MW-1:0] diff;
    logic [MW:0]     t_sub;

    recip_rom u_rom (
        .addr (req_q.fb[51:44]),
        .data (seed)
    );

    sig_mul_tree #(.W(MW)) u_mul (
        .a    (mul_a),
        .b    (mul_b),
        .prod (prod)
    );

    assign idle   = (state == S_IDLE);
    assign done   = (state == S_DONE);
    assign fb_ext = {31'b0, req_q.fb};
    assign diff   = {8'b0, req_q.fa, 55'b0} - prod;        // fa*2^55 - q*fb.
    assign t_sub  = {1'b1, {MW{1'b0}}} - prod[115:57];     // 2 - b*x.
    assign r_hi   = r[RW-1] ? '0 : r[81:24];

    // operand select for the shared multiplier.
    always_comb begin
        mul_a = {req_q.fa, 5'b0};
        mul_b = {req_q.fb, 5'b0};
        case (state)
            S_NR_A: begin
                mul_a = {req_q.fb, 5'b0};
                mul_b = x;
            end
            S_NR_B: begin
                mul_a = x;
                mul_b = e;
            end
            S_QUOT: mul_b = x;
            S_CORR: begin
                if (!ph[0]) begin
                    mul_a = {1'b0, q};
                    mul_b = {5'b0, req_q.fb};
                end else begin
                    mul_a = r_hi;                          // r/fb estimate.
                    mul_b = x;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
            iter  <= '0;
            ph    <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        iter  <= req.db ? 3'(`MD_NR_DP) : 3'(`MD_NR_SP);
                        ph    <= '0;
                        state <= (req.op == OP_DIV) ? S_SEED : S_MUL;
                    end
                end
                S_MUL:  state <= S_DONE;
                S_SEED: state <= S_NR_A;
                S_NR_A: state <= S_NR_B;
                S_NR_B: begin
                    iter  <= iter - 3'd1;
                    state <= (iter == 3'd1) ? S_QUOT : S_NR_A;
                end
                S_QUOT: state <= S_CORR;
                S_CORR: begin
                    if (ph != 2'd3) begin
                        ph <= ph + 2'd1;
                    end else if (!r[RW-1] && r < fb_ext) begin
                        state <= S_DONE;
                    end
                end
                S_DONE: if (ack) state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: if (start) req_q <= req;
            S_MUL: begin
                rsp.fq  <= {prod[115:60], |prod[59:0]};
                rsp.tag <= req_q.tag;
            end
            S_SEED: x <= {2'b01, seed, 48'b0};
            S_NR_A: e <= t_sub[MW-1:0];
            S_NR_B: x <= prod[114:57];
            S_QUOT: q <= prod[115:59];                         // a*x.
            S_CORR: begin
                if (!ph[0]) begin
                    r <= diff[RW-1:0];
                end else if (ph == 2'd1) begin
                    q <= q + {26'b0, prod[115:85]};
                end else if (r[RW-1]) begin
                    q <= q - 57'd1;
                    r <= r + fb_ext;
                end else if (r >= fb_ext) begin
                    q <= q + 57'd1;
                    r <= r - fb_ext;
                end else begin
                    rsp.fq  <= {q[55:0], |r};                  // sticky from remainder.
                    rsp.tag <= req_q.tag;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/sig_mul_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

module sig_mul_tree #(
    parameter int W = 58
) (
    input  wire logic [W-1:0]   a,
    input  wire logic [W-1:0]   b,
    output logic      [2*W-1:0] prod
);

    logic [2*W-1:0] pp [W];

    // one shifted copy of a per set bit of b.
    for (genvar i = 0; i < W; i++) begin : g_pp
        assign pp[i] = b[i] ? ({{W{1'b0}}, a} << i) : '0;
    end

    // plain sum, synthesis rebuilds it as a carry-save tree.
    always_comb begin
        prod = '0;
        for (int i = 0; i < W; i++) begin
            prod = prod + pp[i];
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
+incdir+tests
hw/fmd_pkg.sv
hw/recip_rom.sv
hw/sig_mul_tree.sv
hw/sig_md_lane.sv
hw/md_dispatch.sv
hw/md_collect.sv
hw/sig_md_cluster.sv
tests/tb_sig_md.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -f project.f --top-module tb_sig_md -o tb_sig_md \
    && ./obj_dir/tb_sig_md 2>&1 | tee sim.log

grep -qx "Done: no errors" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tests/md_ref_model.svh ====
`ifndef MD_REF_MODEL_SVH
`define MD_REF_MODEL_SVH

`include "fmd_macros.svh"

// top 56 bits of (fa*2^5)*(fb*2^5), then the or of the rest.
function automatic logic [`MD_FQ_W-1:0] mul_expect(
    input logic [`MD_SIG_W-1:0] fa,
    input logic [`MD_SIG_W-1:0] fb
);
    logic [115:0] p;
    p = 116'({fa, 5'b0}) * 116'({fb, 5'b0});
    return {p[115:60], |p[59:0]};
endfunction

// floor(fa*2^55 / fb), sticky set on a nonzero remainder.
function automatic logic [`MD_FQ_W-1:0] div_expect(
    input logic [`MD_SIG_W-1:0] fa,
    input logic [`MD_SIG_W-1:0] fb
);
    logic [107:0] num;
    logic [107:0] quo;
    logic [107:0] rem;
    num = {fa, 55'b0};
    quo = num / 108'(fb);
    rem = num % 108'(fb);
    return {quo[55:0], |rem};
endfunction

function automatic logic [`MD_FQ_W-1:0] fq_expect(
    input md_op_e               op,
    input logic [`MD_SIG_W-1:0] fa,
    input logic [`MD_SIG_W-1:0] fb
);
    if (op == OP_MUL) begin
        return mul_expect(fa, fb);
    end
    return div_expect(fa, fb);
endfunction

`endif

// ==== tests/tb_sig_md.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fmd_macros.svh"

module tb_sig_md import fmd_pkg::*; ();

    localparam int TAGS  = 1 << `MD_TAG_W;
    localparam int N_REQ = 9 + `MD_LANES + 2;
    localparam logic [52:0] ONE  = 53'h10000000000000;
    localparam logic [52:0] ALL1 = {53{1'b1}};

    logic    clk;
    logic    arst_n;
    logic    req_valid;
    md_req_t req;
    logic    busy;
    logic    rsp_valid;
    md_rsp_t rsp;

    integer                seed = 80730;
    logic [`MD_FQ_W-1:0]   exp_fq [TAGS];
    int                    issued [TAGS];    // driver side.
    int                    returned [TAGS];  // monitor side.
    int                    n_sent;
    int                    n_recv;
    logic [`MD_TAG_W-1:0]  next_tag;
    logic                  saw_busy;

    `include "md_ref_model.svh"

    sig_md_cluster uut (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_errors();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [52:0] rand_sig();
        logic [63:0] v;
        v = {$random(seed), $random(seed)};
        return {1'b1, v[51:0]};
    endfunction

    function automatic logic [52:0] rand_sp_sig();
        logic [31:0] v;
        v = $random(seed);
        return {1'b1, v[22:0], 29'b0};  // single precision fraction only.
    endfunction

    // waits for a free lane, then strobes one request.
    task automatic send_req(input md_op_e op, input logic db,
                            input logic [52:0] fa, input logic [52:0] fb);
        logic [`MD_TAG_W-1:0] tag;
        tag = next_tag;
        @(posedge clk);
        while (busy) begin
            saw_busy = 1'b1;
            @(posedge clk);
        end
        @(negedge clk);
        exp_fq[tag] = fq_expect(op, fa, fb);
        issued[tag]++;
        req.op    = op;
        req.db    = db;
        req.fa    = fa;
        req.fb    = fb;
        req.tag   = tag;
        req_valid = 1'b1;
        @(negedge clk);
        req_valid = 1'b0;
        next_tag++;
        n_sent++;
    endtask

    task automatic wait_drain();
        while (n_recv != n_sent) @(negedge clk);
    endtask

    // scoreboard, matched by tag.
    always @(posedge clk) begin
        if (arst_n && rsp_valid) begin
            assert (issued[rsp.tag] == returned[rsp.tag] + 1) else begin
                $display("response with tag %0d at %0d ns was not pending", rsp.tag, $time);
                stop_with_errors();
            end
            assert (rsp.fq === exp_fq[rsp.tag]) else begin
                $display("Mismatch at %0d ns: rsp.fq (tag %0d) got %h expected %h",
                         $time, rsp.tag, rsp.fq, exp_fq[rsp.tag]);
                stop_with_errors();
            end
            returned[rsp.tag]++;
            n_recv++;
        end
    end

    task automatic check_idle_after_reset();
        repeat (5) begin
            @(posedge clk);
            assert (busy === 1'b0) else begin
                $display("Mismatch at %0d ns: busy got %b expected 0", $time, busy);
                stop_with_errors();
            end
            assert (rsp_valid === 1'b0) else begin
                $display("Mismatch at %0d ns: rsp_valid got %b expected 0", $time, rsp_valid);
                stop_with_errors();
            end
        end
    endtask

    task automatic test_mul();
        logic [52:0] a;
        logic [52:0] b;
        a = rand_sig();
        b = rand_sig();
        send_req(OP_MUL, 1'b1, ONE, ONE);
        send_req(OP_MUL, 1'b0, ALL1, ALL1);
        send_req(OP_MUL, 1'b1, 53'h18000000000000, 53'h14000000000000); // low bits zero.
        send_req(OP_MUL, 1'b0, a, b);
        wait_drain();
    endtask

    task automatic test_div_dp();
        logic [52:0] a;
        a = rand_sig();
        send_req(OP_DIV, 1'b1, a, a);
        send_req(OP_DIV, 1'b1, ONE, 53'h18000000000000);
        send_req(OP_DIV, 1'b1, ALL1, ONE);
        wait_drain();
    endtask

    task automatic test_div_sp();
        logic [52:0] a;
        logic [52:0] b;
        a = rand_sp_sig();
        b = rand_sp_sig();
        send_req(OP_DIV, 1'b0, ONE, 53'h18000000000000);
        send_req(OP_DIV, 1'b0, a, b);
        wait_drain();
    endtask

    // first lanes get divides so that all of them are occupied.
    task automatic test_burst();
        logic [52:0] a;
        logic [52:0] b;
        logic [31:0] rnd;
        md_op_e      op;
        saw_busy = 1'b0;
        for (int i = 0; i < `MD_LANES + 2; i++) begin
            a   = rand_sig();
            b   = rand_sig();
            rnd = $random(seed);
            op  = (i < `MD_LANES || rnd[0]) ? OP_DIV : OP_MUL;
            send_req(op, rnd[1], a, b);
        end
        assert (saw_busy) else begin
            $display("busy never went high with all lanes occupied");
            stop_with_errors();
        end
        wait_drain();
    endtask

    initial begin
        repeat (N_REQ * 40 + 200) @(posedge clk);
        $display("watchdog expired, %0d of %0d responses received", n_recv, n_sent);
        stop_with_errors();
    end

    initial begin
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        next_tag  = '0;
        saw_busy  = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        check_idle_after_reset();
        test_mul();
        test_div_dp();
        test_div_sp();
        test_burst();

        if (n_recv == n_sent && n_sent == N_REQ) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("%0d of %0d requests answered", n_recv, N_REQ);
            stop_with_errors();
        end
    end

endmodule

`default_nettype wire
